/* vlog.f */
mem_pkg.sv
mem_intf.sv
mem_wr_intf.sv
mem_reset_fsm.sv
mem_ram_array.sv
mem_ram_sp.sv
mem_ram_sp_top.sv
tb_mem_ram_sp.sv

/* Bender.yml */
package:
  name: mem_ram_sp

sources:
  - files:
      - mem_pkg.sv
      - mem_intf.sv
      - mem_wr_intf.sv
      - mem_reset_fsm.sv
      - mem_ram_array.sv
      - mem_ram_sp.sv
      - mem_ram_sp_top.sv
  - target: simulation
    files:
      - tb_mem_ram_sp.sv

/* tb_mem_ram_sp.sv */
// --------------------
// Self-checking random testbench for the single-port RAM top level.
// A reference memory model and ack queues are checked on every cycle.
// --------------------
`timescale 1ns/10ps
`default_nettype none

module tb_mem_ram_sp
    import mem_pkg::*;
();

    localparam int          CLK_PERIOD    = 8;
    localparam int          RST_CYCLES    = 8;
    localparam int          NUM_REQ       = 600;
    localparam int          NUM_WR_ACK    = 48;
    localparam int          WR_ACK_DELAY  = 1;
    localparam int          RDY_TIMEOUT   = 4 * DEPTH;
    localparam int          DRAIN_TIMEOUT = 32;
    localparam logic [31:0] SEED          = 32'd66159;

    logic  mem_if;
    logic  rst;
    logic  req;
    logic  wr;
    addr_t addr;
    data_t wr_data;
    logic  rdy;
    logic  wr_ack;
    logic  rd_ack;
    data_t rd_data;

    logic [31:0] lfsr;
    string       test_name;
    int          mismatch_cnt = 0;
    int          proto_cnt    = 0;
    int          timeout_cnt  = 0;

    // --------------------
    // Reference model
    // --------------------
    data_t model [DEPTH];
    data_t rd_exp_q  [$];
    addr_t rd_addr_q [$];
    int    rd_due_q  [$];
    int    wr_due_q  [$];

    int    cyc      = 0;
    int    clr_cnt  = 0;
    logic  rdy_seen = 1'b0;
    logic  rst_q    = 1'b0;

    mem_ram_sp_top u_mem_ram_sp_top (
        .mem_if  (mem_if),
        .rst     (rst),
        .req     (req),
        .wr      (wr),
        .addr    (addr),
        .wr_data (wr_data),
        .rdy     (rdy),
        .wr_ack  (wr_ack),
        .rd_ack  (rd_ack),
        .rd_data (rd_data)
    );

    initial begin
        mem_if = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) mem_if = ~mem_if;
        end
    end

    // Galois LFSR, taps 32 22 2 1, shifted right
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        lfsr_step = s >> 1;
        if (s[0]) begin
            lfsr_step = lfsr_step ^ 32'h8020_0003;
        end
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        int          i;
        val = '0;
        for (i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            val  = {val[30:0], lfsr[0]};
        end
        return val;
    endfunction

    // --------------------
    // Monitor
    // --------------------
    // Sampled mid-cycle, an accept here lands on the next rising edge
    task automatic check_rd_ack();
        data_t exp;
        addr_t a;
        int    due;
        if (rd_ack === 1'b1) begin
            if (rd_exp_q.size() == 0) begin
                $display("ERROR %s: rd_ack with no read outstanding", test_name);
                proto_cnt++;
            end else begin
                exp = rd_exp_q.pop_front();
                a   = rd_addr_q.pop_front();
                due = rd_due_q.pop_front();
                if (due != cyc) begin
                    $display("MISMATCH %s: rd latency addr %0d expected %0d actual %0d",
                             test_name, a, RD_LATENCY, RD_LATENCY + cyc - due);
                    mismatch_cnt++;
                end
                if (rd_data !== exp) begin
                    $display("MISMATCH %s: rd_data addr %0d expected %h actual %h",
                             test_name, a, exp, rd_data);
                    mismatch_cnt++;
                end
            end
        end
        if (rd_due_q.size() > 0 && rd_due_q[0] < cyc) begin
            $display("ERROR %s: no rd_ack for the read of address %0d",
                     test_name, rd_addr_q[0]);
            proto_cnt++;
            void'(rd_exp_q.pop_front());
            void'(rd_addr_q.pop_front());
            void'(rd_due_q.pop_front());
        end
    endtask

    task automatic check_wr_ack();
        int due;
        if (wr_ack === 1'b1) begin
            if (wr_due_q.size() == 0) begin
                $display("ERROR %s: wr_ack with no write outstanding", test_name);
                proto_cnt++;
            end else begin
                due = wr_due_q.pop_front();
                if (due != cyc) begin
                    $display("MISMATCH %s: wr latency expected %0d actual %0d",
                             test_name, WR_ACK_DELAY, WR_ACK_DELAY + cyc - due);
                    mismatch_cnt++;
                end
            end
        end
        if (wr_due_q.size() > 0 && wr_due_q[0] < cyc) begin
            $display("ERROR %s: an accepted write got no wr_ack", test_name);
            proto_cnt++;
            void'(wr_due_q.pop_front());
        end
    endtask

    // rdy must first show up DEPTH+1 cycles after rst falls, then stay high
    task automatic track_rdy();
        if (rst) begin
            clr_cnt  = 0;
            rdy_seen = 1'b0;
        end else if (!rdy_seen) begin
            clr_cnt++;
            if (rdy === 1'b1) begin
                rdy_seen = 1'b1;
                if (clr_cnt != DEPTH + 1) begin
                    $display("MISMATCH %s: rdy rise cycle expected %0d actual %0d",
                             test_name, DEPTH + 1, clr_cnt);
                    mismatch_cnt++;
                end
            end
        end else if (rdy !== 1'b1) begin
            $display("ERROR %s: rdy dropped without a reset", test_name);
            proto_cnt++;
        end
    endtask

    task automatic restart_model();
        int i;
        for (i = 0; i < DEPTH; i++) begin
            model[i] = RESET_VAL;
        end
        rd_exp_q.delete();
        rd_addr_q.delete();
        rd_due_q.delete();
        wr_due_q.delete();
    endtask

    always @(negedge mem_if) begin
        if (rst && rst_q) begin
            if (rdy !== 1'b0 || wr_ack !== 1'b0 || rd_ack !== 1'b0) begin
                $display("ERROR %s: rdy or an ack is not low during reset", test_name);
                proto_cnt++;
            end
        end else begin
            check_rd_ack();
            check_wr_ack();
        end
        track_rdy();
        if (rst) begin
            restart_model();
        end else if (req && rdy === 1'b1) begin
            if (wr) begin
                model[addr] = wr_data;
                wr_due_q.push_back(cyc + WR_ACK_DELAY);
            end else begin
                rd_exp_q.push_back(model[addr]);
                rd_addr_q.push_back(addr);
                rd_due_q.push_back(cyc + RD_LATENCY);
            end
        end
        rst_q = rst;
        cyc++;
    end

    // --------------------
    // Stimulus
    // --------------------
    task automatic drive_request(input logic v, input logic w, input addr_t a, input data_t d);
        @(posedge mem_if);
        req     <= v;
        wr      <= w;
        addr    <= a;
        wr_data <= d;
    endtask

    task automatic drive_random(input logic write_only, output logic issued);
        logic  v;
        logic  w;
        addr_t a;
        data_t d;
        v = write_only ? 1'b1 : (rand_bits(2) != 0);
        w = write_only ? 1'b1 : rand_bits(1);
        a = rand_bits(ADDR_WID);
        d = rand_bits(DATA_WID);
        drive_request(v, w, a, d);
        issued = v;
    endtask

    task automatic apply_reset(input logic with_writes);
        logic got;
        int   i;
        @(posedge mem_if);
        rst <= 1'b1;
        req <= 1'b0;
        for (i = 1; i < RST_CYCLES; i++) begin
            if (with_writes) begin
                drive_random(1'b1, got);
            end else begin
                @(posedge mem_if);
            end
        end
        @(posedge mem_if);
        rst <= 1'b0;
    endtask

    task automatic wait_rdy();
        int n;
        n = 0;
        @(negedge mem_if);
        while (rdy !== 1'b1 && n < RDY_TIMEOUT) begin
            @(negedge mem_if);
            n++;
        end
        if (rdy !== 1'b1) begin
            $display("ERROR %s: timed out waiting for rdy", test_name);
            timeout_cnt++;
        end
    endtask

    // Idle the port until every outstanding ack has come back
    task automatic drain();
        int n;
        n = 0;
        drive_request(1'b0, 1'b0, '0, '0);
        @(negedge mem_if);
        while ((rd_due_q.size() != 0 || wr_due_q.size() != 0) && n < DRAIN_TIMEOUT) begin
            @(negedge mem_if);
            n++;
        end
        if (rd_due_q.size() != 0 || wr_due_q.size() != 0) begin
            $display("ERROR %s: timed out waiting for outstanding acks", test_name);
            timeout_cnt++;
        end
    endtask

    task automatic read_all();
        int i;
        for (i = 0; i < DEPTH; i++) begin
            drive_request(1'b1, 1'b0, addr_t'(i), '0);
        end
        drain();
    endtask

    initial begin
        logic got;
        int   issued;
        int   i;
        lfsr    = SEED;
        rst     <= 1'b1;
        req     <= 1'b0;
        wr      <= 1'b0;
        addr    <= '0;
        wr_data <= '0;

        test_name = "reset";
        apply_reset(1'b0);
        wait_rdy();

        test_name = "cleared";
        read_all();

        test_name = "random";
        issued = 0;
        while (issued < NUM_REQ) begin
            drive_random(1'b0, got);
            if (got) begin
                issued++;
            end
        end
        drain();

        // Writes only, some back to back and some with a gap
        test_name = "write_ack";
        for (i = 0; i < NUM_WR_ACK; i++) begin
            drive_random(1'b1, got);
            if (rand_bits(1)) begin
                drive_request(1'b0, 1'b0, '0, '0);
            end
        end
        drain();

        test_name = "held_off";
        apply_reset(1'b1);
        for (i = 0; i < DEPTH - 2; i++) begin
            drive_random(1'b1, got);
        end
        drive_request(1'b0, 1'b0, '0, '0);
        wait_rdy();
        read_all();

        $display("errors: %0d mismatches, %0d protocol, %0d timeouts",
                 mismatch_cnt, proto_cnt, timeout_cnt);
        if (mismatch_cnt + proto_cnt + timeout_cnt == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule : tb_mem_ram_sp

`default_nettype wire

/* mem_ram_sp_top.sv */
// --------------------
// Top level of the single-port RAM with plain ports.
// Bundles the ports into the memory interface for the RAM.
// --------------------
`timescale 1ns/10ps
`default_nettype none

module mem_ram_sp_top
    import mem_pkg::*;
(
    input  logic  mem_if,
    input  logic  rst,
    input  logic  req,
    input  logic  wr,
    input  addr_t addr,
    input  data_t wr_data,
    output logic  rdy,
    output logic  wr_ack,
    output logic  rd_ack,
    output data_t rd_data
);

    // --------------------
    // Port bundle
    // --------------------
    mem_intf ram_if (.mem_if(mem_if));

    // Requests in
    assign ram_if.rst     = rst;
    assign ram_if.req     = req;
    assign ram_if.wr      = wr;
    assign ram_if.addr    = addr;
    assign ram_if.wr_data = wr_data;

    // Responses out
    assign rdy     = ram_if.rdy;
    assign wr_ack  = ram_if.wr_ack;
    assign rd_ack  = ram_if.rd_ack;
    assign rd_data = ram_if.rd_data;

    // --------------------
    // RAM
    // --------------------
    mem_ram_sp u_mem_ram_sp (
        .ram_if (ram_if)
    );

endmodule : mem_ram_sp_top

`default_nettype wire

/* mem_ram_sp.sv */
// --------------------
// Single-port RAM with built-in clearing after reset.
// Requests pass through the reset FSM; read data comes straight from the array.
// --------------------
`timescale 1ns/10ps
`default_nettype none

module mem_ram_sp
    import mem_pkg::*;
(
    mem_intf.peripheral ram_if
);

    // --------------------
    // Local interfaces
    // --------------------
    mem_wr_intf wr_in_if  (.mem_if(ram_if.mem_if));
    mem_wr_intf wr_out_if (.mem_if(ram_if.mem_if));
    mem_intf    arr_if    (.mem_if(ram_if.mem_if));

    // Request port onto the write path
    assign wr_in_if.rst  = ram_if.rst;
    assign wr_in_if.req  = ram_if.req;
    assign wr_in_if.en   = ram_if.wr;
    assign wr_in_if.addr = ram_if.addr;
    assign wr_in_if.data = ram_if.wr_data;

    assign ram_if.rdy    = wr_in_if.rdy;
    assign ram_if.wr_ack = wr_in_if.ack;

    // --------------------
    // Reset FSM
    // --------------------
    mem_reset_fsm u_mem_reset_fsm (
        .wr_in_if  (wr_in_if),
        .wr_out_if (wr_out_if)
    );

    // Write path onto the array
    assign arr_if.rst     = wr_out_if.rst;
    assign arr_if.req     = wr_out_if.req;
    assign arr_if.wr      = wr_out_if.en;
    assign arr_if.addr    = wr_out_if.addr;
    assign arr_if.wr_data = wr_out_if.data;

    assign wr_out_if.ack  = arr_if.wr_ack;

    // --------------------
    // Storage array
    // --------------------
    mem_ram_array u_mem_ram_array (
        .arr_if (arr_if)
    );

    // Read response bypasses the FSM
    assign ram_if.rd_ack  = arr_if.rd_ack;
    assign ram_if.rd_data = arr_if.rd_data;

    // --------------------
    // Checks
    // --------------------
    // External write ack only for a write accepted at the port
    a_wr_ack_accepted : assert property (
        @(posedge ram_if.mem_if) disable iff (ram_if.rst)
        ram_if.wr_ack |-> $past(ram_if.req && ram_if.wr && ram_if.rdy, WR_LATENCY)
    );

endmodule : mem_ram_sp

`default_nettype wire

/* mem_ram_array.sv */
// --------------------
// Storage array with one-cycle write ack and a two-stage read pipeline.
// Accepts a request every cycle, so it has no rdy.
// --------------------
`timescale 1ns/10ps
`default_nettype none

module mem_ram_array
    import mem_pkg::*;
(
    mem_intf.array arr_if
);

    // --------------------
    // Storage
    // --------------------
    data_t mem [DEPTH];

    logic  wr_req;
    logic  rd_req;

    assign wr_req = arr_if.req && arr_if.wr;
    assign rd_req = arr_if.req && !arr_if.wr;

    // Write lands on the accept edge
    always_ff @(posedge arr_if.mem_if) begin
        if (wr_req) begin
            mem[arr_if.addr] <= arr_if.wr_data;
        end
    end

    // --------------------
    // Read pipeline
    // --------------------
    logic  rd_vld_s1;
    data_t rd_data_s1;
    logic  rd_vld_s2;
    data_t rd_data_s2;
    logic  wr_ack_q;

    // Stage one is the registered array read
    always_ff @(posedge arr_if.mem_if) begin
        if (rd_req) begin
            rd_data_s1 <= mem[arr_if.addr];
        end
        if (rd_vld_s1) begin
            rd_data_s2 <= rd_data_s1;
        end
    end

    always_ff @(posedge arr_if.mem_if) begin
        if (arr_if.rst) begin
            rd_vld_s1 <= 1'b0;
            rd_vld_s2 <= 1'b0;
            wr_ack_q  <= 1'b0;
        end else begin
            rd_vld_s1 <= rd_req;
            rd_vld_s2 <= rd_vld_s1;
            wr_ack_q  <= wr_req;
        end
    end

    assign arr_if.wr_ack  = wr_ack_q;
    assign arr_if.rd_ack  = rd_vld_s2;
    assign arr_if.rd_data = rd_data_s2;

    // --------------------
    // Checks
    // --------------------
    // Every read response traces back to a read accepted RD_LATENCY ago
    // and carries the word that was stored there at that edge
    a_rd_ack_latency : assert property (
        @(posedge arr_if.mem_if) disable iff (arr_if.rst)
        arr_if.rd_ack |-> $past(rd_req, RD_LATENCY) &&
            (arr_if.rd_data == $past(mem[arr_if.addr], RD_LATENCY))
    );

endmodule : mem_ram_array

`default_nettype wire

/* mem_reset_fsm.sv */
// --------------------
// Clears every word to RESET_VAL after reset, then passes requests through.
// Sits on the write path between the request port and the storage array.
// --------------------
`timescale 1ns/10ps
`default_nettype none

module mem_reset_fsm
    import mem_pkg::*;
(
    mem_wr_intf.sink   wr_in_if,
    mem_wr_intf.source wr_out_if
);

    // --------------------
    // State
    // --------------------
    typedef enum logic {
        ST_CLEAR,
        ST_RUN
    } state_t;

    state_t state;
    addr_t  clr_addr;

    // Low for the cycle that returns the last clearing write's ack
    logic   ack_en;

    always_ff @(posedge wr_in_if.mem_if) begin
        if (wr_in_if.rst) begin
            state    <= ST_CLEAR;
            clr_addr <= '0;
            ack_en   <= 1'b0;
        end else begin
            ack_en <= (state == ST_RUN);
            if (state == ST_CLEAR) begin
                clr_addr <= clr_addr + 1'b1;
                if (clr_addr == addr_t'(DEPTH - 1)) begin
                    state <= ST_RUN;
                end
            end
        end
    end

    // --------------------
    // Outgoing request
    // --------------------
    // One clearing write per cycle and no added latency when running
    assign wr_out_if.rst  = wr_in_if.rst;
    assign wr_out_if.req  = (state == ST_CLEAR) ? 1'b1      : wr_in_if.req;
    assign wr_out_if.en   = (state == ST_CLEAR) ? 1'b1      : wr_in_if.en;
    assign wr_out_if.addr = (state == ST_CLEAR) ? clr_addr  : wr_in_if.addr;
    assign wr_out_if.data = (state == ST_CLEAR) ? RESET_VAL : wr_in_if.data;

    // --------------------
    // Back to requester
    // --------------------
    assign wr_in_if.rdy = (state == ST_RUN);

    // Clearing writes are acked by the array but hidden here
    assign wr_in_if.ack = wr_out_if.ack && ack_en;

    // --------------------
    // Checks
    // --------------------
    // rdy comes up only after the last word is cleared, and that word's ack stays hidden
    a_rdy_after_clear : assert property (
        @(posedge wr_in_if.mem_if) disable iff (wr_in_if.rst)
        $rose(wr_in_if.rdy) |->
            $past(wr_out_if.req && wr_out_if.en) &&
            ($past(wr_out_if.addr) == addr_t'(DEPTH - 1)) && !wr_in_if.ack
    );

    // Clearing writes go out every cycle in ascending address order
    a_clear_sequence : assert property (
        @(posedge wr_in_if.mem_if) disable iff (wr_in_if.rst)
        (state == ST_CLEAR && clr_addr != addr_t'(DEPTH - 1)) |=>
            wr_out_if.req && wr_out_if.en &&
            (wr_out_if.addr == addr_t'($past(wr_out_if.addr) + 1'b1))
    );

endmodule : mem_reset_fsm

`default_nettype wire

/* mem_wr_intf.sv */
// --------------------
// Write-path interface between the request side and the reset FSM.
// en selects a write; req with en low is a read passed on untouched.
// --------------------
`timescale 1ns/10ps
`default_nettype none

interface mem_wr_intf
    import mem_pkg::*;
(
    input logic mem_if
);

    // From source
    logic  rst;
    logic  en;
    logic  req;
    addr_t addr;
    data_t data;

    // From sink
    logic  rdy;
    logic  ack;

    modport source (
        input  mem_if,
        output rst, en, req, addr, data,
        input  rdy, ack
    );

    modport sink (
        input  mem_if,
        input  rst, en, req, addr, data,
        output rdy, ack
    );

endinterface : mem_wr_intf

`default_nettype wire

/* mem_intf.sv */
// --------------------
// Full memory request/response interface, reads and writes on one port.
// Controller drives requests, peripheral or array returns responses.
// --------------------
`timescale 1ns/10ps
`default_nettype none

interface mem_intf
    import mem_pkg::*;
(
    input logic mem_if
);

    // Request side
    logic  rst;
    logic  req;
    logic  wr;
    addr_t addr;
    data_t wr_data;

    // Response side
    logic  rdy;
    logic  wr_ack;
    logic  rd_ack;
    data_t rd_data;

    modport controller (
        input  mem_if,
        output rst, req, wr, addr, wr_data,
        input  rdy, wr_ack, rd_ack, rd_data
    );

    modport peripheral (
        input  mem_if,
        input  rst, req, wr, addr, wr_data,
        output rdy, wr_ack, rd_ack, rd_data
    );

    // Storage array never stalls, so no rdy from it
    modport array (
        input  mem_if,
        input  rst, req, wr, addr, wr_data,
        output wr_ack, rd_ack, rd_data
    );

endinterface : mem_intf

`default_nettype wire

/* mem_pkg.sv */
// --------------------
// RAM geometry, latencies and clearing value shared by the RAM blocks.
// Import with mem_pkg::* in the module header.
// --------------------
`default_nettype none

package mem_pkg;

    // --------------------
    // Geometry
    // --------------------
    localparam int ADDR_WID = 6;
    localparam int DATA_WID = 16;
    localparam int DEPTH    = 2 ** ADDR_WID;

    typedef logic [ADDR_WID-1:0] addr_t;
    typedef logic [DATA_WID-1:0] data_t;

    // --------------------
    // Contents after clearing
    // --------------------
    // Written to every word by the reset FSM
    localparam data_t RESET_VAL = 16'hA5C3;

    // --------------------
    // Latencies
    // --------------------
    // Cycles from an accepted write to wr_ack
    localparam int WR_LATENCY = 1;

    // Cycles from an accepted read to rd_ack with rd_data
    localparam int RD_LATENCY = 2;

endpackage : mem_pkg

`default_nettype wire
